// File: logic/lzs_pkg.sv
// LZS format constants; the first stream bit sits at the msb of each 16-bit input word
package lzs_pkg;

   localparam int IN_W       = 16;
   localparam int WIN_W      = 13;   // widest token plus flag
   localparam int WIDTH_W    = 4;
   localparam int BUF_W      = 2 * IN_W;
   localparam int FILL_W     = $clog2(BUF_W + 1);

   localparam int HIST_AW    = 11;   // 2 kB history
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_AW    = 4;
   localparam int FIFO_SLACK = 2;    // room for the copy pipeline

   // token widths in stream bits
   localparam int LIT_W  = 9;
   localparam int SREF_W = 9;
   localparam int LREF_W = 13;
   localparam int SOFF_W = 7;
   localparam int LEN_W  = 2;
   localparam int NIB_W  = 4;
   localparam int END_W  = 9;

   localparam logic [END_W-1:0] END_CODE = 9'b110000000;

   // decode controller states
   localparam logic [2:0] S_IDLE     = 3'd0;
   localparam logic [2:0] S_TOKEN    = 3'd1;
   localparam logic [2:0] S_LEN1     = 3'd2;
   localparam logic [2:0] S_LEN2     = 3'd3;
   localparam logic [2:0] S_EXT      = 3'd4;
   localparam logic [2:0] S_COPY_EXT = 3'd5;   // copy, then another nibble
   localparam logic [2:0] S_COPY_RET = 3'd6;   // copy, then next token
   localparam logic [2:0] S_END      = 3'd7;

   // same 13-bit window seen as literal or as back-reference
   typedef union packed {
      struct packed {
         logic       is_ref;
         logic [7:0] lit_byte;
         logic [3:0] pad;
      } lit;
      struct packed {
         logic               is_ref;
         logic               short_off;
         logic [HIST_AW-1:0] off_field;   // short offset is the top 7 bits
      } bref;
   } lzs_token_u;

endpackage

// File: logic/history_ram.sv
// 2048 x 8 history store; read data returns one cycle after raddr, a same-address read returns old data
module history_ram (
   input  logic                       clk,
   input  logic                       we,
   input  logic [lzs_pkg::HIST_AW-1:0] waddr,
   input  logic [7:0]                 wdata,
   input  logic [lzs_pkg::HIST_AW-1:0] raddr,
   output logic [7:0]                 rdata
);
   import lzs_pkg::*;

   logic [7:0] mem [2**HIST_AW];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // registered read port
   always_ff @(posedge clk) begin
      rdata <= mem[raddr];
   end

endmodule

// File: logic/out_fifo.sv
// byte FIFO of FIFO_DEPTH entries; the writer must hold off on afull, writes while full are not guarded
module out_fifo (
   input  logic       clk,
   input  logic       rst,
   input  logic [7:0] wdata,
   input  logic       we,
   output logic       afull,
   output logic [7:0] rdata,
   output logic       valid,
   input  logic       ready
);
   import lzs_pkg::*;

   logic [7:0]         mem [FIFO_DEPTH];
   logic [FIFO_AW-1:0] wptr;
   logic [FIFO_AW-1:0] rptr;
   logic [FIFO_AW:0]   count;   // one extra bit for full
   logic               rd;

   assign rd    = valid && ready;
   assign valid = (count != '0);
   assign rdata = mem[rptr];   // head visible the cycle after the write
   assign afull = (count >= FIFO_DEPTH - FIFO_SLACK);

   always_ff @(posedge clk) begin
      if (we) begin
         mem[wptr] <= wdata;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end else begin
         if (we) begin
            wptr <= wptr + 1'b1;
         end
         if (rd) begin
            rptr <= rptr + 1'b1;
         end
         case ({we, rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // idle or write and read together
         endcase
      end
   end

endmodule

// File: logic/bit_aligner.sv
// MSB-first bit aligner; a window is only offered with 13 bits held, so the stream tail needs zero padding
module bit_aligner (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [lzs_pkg::IN_W-1:0]      in_data,
   input  logic                          in_valid,
   output logic                          in_ready,
   output lzs_pkg::lzs_token_u           stream_data,
   output logic                          stream_valid,
   input  logic [lzs_pkg::WIDTH_W-1:0]   stream_width,
   input  logic                          stream_ack
);
   import lzs_pkg::*;

   logic [BUF_W-1:0]   bits_q;      // valid bits packed at the top
   logic [FILL_W-1:0]  fill_q;
   logic [WIDTH_W-1:0] drop;
   logic [BUF_W-1:0]   bits_kept;
   logic [FILL_W-1:0]  fill_kept;
   logic [BUF_W-1:0]   word_pos;
   logic               take;

   assign take = in_valid && in_ready;
   assign drop = stream_ack ? stream_width : '0;

   // consumed bits leave from the top, zeros come in below
   assign bits_kept = bits_q << drop;
   assign fill_kept = fill_q - FILL_W'(drop);

   // new word lands just below what is still held
   assign word_pos = {in_data, {IN_W{1'b0}}} >> fill_kept;

   assign in_ready     = (fill_q <= FILL_W'(IN_W));
   assign stream_valid = (fill_q >= FILL_W'(WIN_W));
   assign stream_data  = bits_q[BUF_W-1 -: WIN_W];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bits_q <= '0;   // bits below the fill must stay zero for the OR
         fill_q <= '0;
      end else if (take) begin
         bits_q <= bits_kept | word_pos;
         fill_q <= fill_kept + FILL_W'(IN_W);
      end else begin
         bits_q <= bits_kept;
         fill_q <= fill_kept;
      end
   end

endmodule

// File: logic/lzs_decode_ctl.sv
// LZS token decoder; assumes a well-formed stream, a single end marker and offsets within written history
module lzs_decode_ctl (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          start,
   input  lzs_pkg::lzs_token_u           stream_data,
   input  logic                          stream_valid,
   output logic [lzs_pkg::WIDTH_W-1:0]   stream_width,
   output logic                          stream_ack,
   input  logic                          fifo_afull,
   output logic [7:0]                    out_data,
   output logic                          out_valid,
   output logic                          done
);
   import lzs_pkg::*;

   logic [2:0]         state;
   logic [2:0]         state_nx;
   logic [2:0]         copy_next;
   logic [NIB_W-1:0]   cnt;
   logic [NIB_W-1:0]   cnt_nx;
   logic               cnt_load;
   logic               copy_step;
   logic [HIST_AW-1:0] off;
   logic [HIST_AW-1:0] off_nx;
   logic               off_load;
   logic               lit_we;
   logic [7:0]         lit_q;
   logic               lit_valid;
   logic               copy_valid;
   logic [HIST_AW-1:0] wptr;
   logic [HIST_AW-1:0] rptr;
   logic [7:0]         hist_rdata;
   logic [7:0]         last_byte;

   // where a copy goes once its count runs out
   assign copy_next = (state == S_COPY_EXT) ? S_EXT : S_TOKEN;

   always_comb begin
      state_nx     = state;
      stream_width = '0;
      stream_ack   = 1'b0;
      cnt_nx       = cnt;
      cnt_load     = 1'b0;
      copy_step    = 1'b0;
      off_nx       = off;
      off_load     = 1'b0;
      lit_we       = 1'b0;

      case (state)
         S_IDLE: begin
            if (start) begin
               state_nx = S_TOKEN;
            end
         end

         S_TOKEN: begin
            if (stream_valid && !fifo_afull) begin
               if (stream_data[WIN_W-1 -: END_W] == END_CODE) begin
                  state_nx = S_END;   // marker is left in the aligner
               end else if (!stream_data.lit.is_ref) begin
                  stream_width = WIDTH_W'(LIT_W);
                  stream_ack   = 1'b1;
                  lit_we       = 1'b1;
               end else begin
                  stream_ack = 1'b1;
                  off_load   = 1'b1;
                  state_nx   = S_LEN1;
                  if (stream_data.bref.short_off) begin
                     stream_width = WIDTH_W'(SREF_W);
                     off_nx = HIST_AW'(stream_data.bref.off_field[HIST_AW-1 -: SOFF_W]);
                  end else begin
                     stream_width = WIDTH_W'(LREF_W);
                     off_nx       = stream_data.bref.off_field;
                  end
               end
            end
         end

         S_LEN1: begin
            if (stream_valid) begin
               stream_width = WIDTH_W'(LEN_W);
               stream_ack   = 1'b1;
               cnt_load     = 1'b1;
               state_nx     = S_COPY_RET;
               case (stream_data[WIN_W-1 -: LEN_W])
                  2'b00: cnt_nx = 4'd2;
                  2'b01: cnt_nx = 4'd3;
                  2'b10: cnt_nx = 4'd4;
                  default: begin   // 11 prefix, two more bits follow
                     cnt_load = 1'b0;
                     state_nx = S_LEN2;
                  end
               endcase
            end
         end

         S_LEN2: begin
            if (stream_valid) begin
               stream_width = WIDTH_W'(LEN_W);
               stream_ack   = 1'b1;
               cnt_load     = 1'b1;
               state_nx     = S_COPY_RET;
               case (stream_data[WIN_W-1 -: LEN_W])
                  2'b00: cnt_nx = 4'd5;
                  2'b01: cnt_nx = 4'd6;
                  2'b10: cnt_nx = 4'd7;
                  default: begin
                     cnt_nx   = 4'd8;
                     state_nx = S_COPY_EXT;
                  end
               endcase
            end
         end

         S_EXT: begin
            if (stream_valid) begin
               stream_width = WIDTH_W'(NIB_W);
               stream_ack   = 1'b1;
               cnt_load     = 1'b1;
               cnt_nx       = stream_data[WIN_W-1 -: NIB_W];
               // all ones means yet another nibble after this copy
               if (&stream_data[WIN_W-1 -: NIB_W]) begin
                  state_nx = S_COPY_EXT;
               end else begin
                  state_nx = S_COPY_RET;
               end
            end
         end

         S_COPY_EXT, S_COPY_RET: begin
            if (cnt == '0) begin
               state_nx = copy_next;   // zero nibble ends here
            end else if (!fifo_afull) begin
               copy_step = 1'b1;
               if (cnt == 4'd1) begin
                  state_nx = copy_next;
               end
            end
         end

         default: begin   // S_END holds until reset
            state_nx = S_END;
         end
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state      <= S_IDLE;
         cnt        <= '0;
         lit_valid  <= 1'b0;
         copy_valid <= 1'b0;
         wptr       <= '0;
      end else begin
         state      <= state_nx;
         lit_valid  <= lit_we;
         copy_valid <= copy_step;   // ram data is back next cycle
         if (cnt_load) begin
            cnt <= cnt_nx;
         end else if (copy_step) begin
            cnt <= cnt - 1'b1;
         end
         if (out_valid) begin
            wptr <= wptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (lit_we) begin
         lit_q <= stream_data.lit.lit_byte;
      end
      if (off_load) begin
         off <= off_nx;
      end
      // wptr already covers every earlier byte by the length state
      if (state == S_LEN1) begin
         rptr <= wptr - off;
      end else if (copy_step) begin
         rptr <= rptr + 1'b1;
      end
      if (out_valid) begin
         last_byte <= out_data;   // bypass for offset 1
      end
   end

   history_ram i_history_ram (
      .clk   (clk),
      .we    (out_valid),
      .waddr (wptr),
      .wdata (out_data),
      .raddr (rptr),
      .rdata (hist_rdata)
   );

   // source byte still being written when the pointers meet
   assign out_data  = lit_valid      ? lit_q     :
                      (rptr == wptr) ? last_byte : hist_rdata;
   assign out_valid = lit_valid | copy_valid;
   assign done      = (state == S_END);

endmodule

// File: logic/lzs_decomp_top.sv
// LZS decompressor top; start once after reset, done stays high until the next reset
module lzs_decomp_top (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      start,
   input  logic [lzs_pkg::IN_W-1:0]  in_data,
   input  logic                      in_valid,
   output logic                      in_ready,
   output logic [7:0]                out_data,
   output logic                      out_valid,
   input  logic                      out_ready,
   output logic                      done
);
   import lzs_pkg::*;

   lzs_token_u         stream_data;
   logic               stream_valid;
   logic [WIDTH_W-1:0] stream_width;
   logic               stream_ack;
   logic [7:0]         fifo_wdata;
   logic               fifo_we;
   logic               fifo_afull;

   bit_aligner i_bit_aligner (
      .clk          (clk),
      .rst          (rst),
      .in_data      (in_data),
      .in_valid     (in_valid),
      .in_ready     (in_ready),
      .stream_data  (stream_data),
      .stream_valid (stream_valid),
      .stream_width (stream_width),
      .stream_ack   (stream_ack)
   );

   lzs_decode_ctl i_lzs_decode_ctl (
      .clk          (clk),
      .rst          (rst),
      .start        (start),
      .stream_data  (stream_data),
      .stream_valid (stream_valid),
      .stream_width (stream_width),
      .stream_ack   (stream_ack),
      .fifo_afull   (fifo_afull),
      .out_data     (fifo_wdata),
      .out_valid    (fifo_we),
      .done         (done)
   );

   // back-pressure path ends here via afull
   out_fifo i_out_fifo (
      .clk   (clk),
      .rst   (rst),
      .wdata (fifo_wdata),
      .we    (fifo_we),
      .afull (fifo_afull),
      .rdata (out_data),
      .valid (out_valid),
      .ready (out_ready)
   );

endmodule

// File: verif/tb_lzs_decomp.sv
// directed tests for lzs_decomp_top; reset before each stream, streams end in zero padding words
module tb_lzs_decomp;
   import lzs_pkg::*;

   logic            clk;
   logic            rst;
   logic            start;
   logic [IN_W-1:0] in_data;
   logic            in_valid;
   logic            in_ready;
   logic [7:0]      out_data;
   logic            out_valid;
   logic            out_ready;
   logic            done;

   logic [IN_W-1:0] word_q[$];   // packed input stream
   logic [7:0]      exp_q[$];    // model output bytes
   logic [IN_W-1:0] acc;
   int              nbits;
   logic [31:0]     rng = 32'h48c80518;
   int              cycle_count = 0;
   int              cycle_limit = 2000;
   logic            saw_stall;

   lzs_decomp_top i_lzs_decomp_top (.*);

   initial clk = 1'b0;
   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         stop_with_failure("timeout: the DUT did not finish the stream in time");
      end
   end

   always @(negedge clk) begin
      if (!in_ready) begin
         saw_stall = 1'b1;   // aligner buffer full
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] want);
      if (got !== want) begin
         stop_with_failure($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                     $time, name, got, want));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic want);
      if (got !== want) begin
         stop_with_failure($sformatf("MISMATCH at %0t: %s got %b expected %b",
                                     $time, name, got, want));
      end
   endtask

   task automatic check_token(input string name, input lzs_token_u got, input lzs_token_u want);
      if (got !== want) begin
         stop_with_failure($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                     $time, name, got, want));
      end
   endtask

   // msb-first bit writer
   task automatic put_bits(input logic [15:0] val, input int n);
      for (int i = n - 1; i >= 0; i--) begin
         acc   = {acc[14:0], val[i]};
         nbits = nbits + 1;
         if (nbits == 16) begin
            word_q.push_back(acc);
            nbits = 0;
         end
      end
   endtask

   task automatic flush_word();
      if (nbits != 0) begin
         put_bits(16'h0, 16 - nbits);
      end
   endtask

   task automatic clear_stream();
      word_q.delete();
      exp_q.delete();
      acc   = '0;
      nbits = 0;
   endtask

   task automatic add_literal(input logic [7:0] b);
      put_bits(16'h0, 1);
      put_bits({8'h0, b}, 8);
      exp_q.push_back(b);
   endtask

   task automatic add_copy(input int off, input int len);
      int rem;
      if (off < 128) begin
         put_bits(16'b11, 2);
         put_bits(16'(off), 7);
      end else begin
         put_bits(16'b10, 2);
         put_bits(16'(off), 11);
      end
      if (len < 5) begin
         put_bits(16'(len - 2), 2);
      end else if (len < 8) begin
         put_bits(16'(len + 7), 4);   // 1100 is length 5
      end else begin
         put_bits(16'hf, 4);
         rem = len - 8;
         while (rem >= 15) begin
            put_bits(16'hf, 4);
            rem = rem - 15;
         end
         put_bits(16'(rem), 4);
      end
      for (int i = 0; i < len; i++) begin
         exp_q.push_back(exp_q[exp_q.size() - off]);   // overlap reads bytes just added
      end
   endtask

   task automatic close_stream();
      put_bits(16'(END_CODE), 9);
      put_bits(16'h0, 4);   // marker plus zeros fill one 13-bit window
      flush_word();
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #2;
      rst = 1'b1;
      repeat (3) @(posedge clk);
      #2;
      rst = 1'b0;
   endtask

   task automatic feed_words();
      int idx;
      idx = 0;
      while (idx < word_q.size()) begin
         @(posedge clk);
         #2;
         in_data  = word_q[idx];
         in_valid = 1'b1;
         @(negedge clk);
         if (in_ready) begin
            idx++;
         end
      end
      @(posedge clk);
      #2;
      in_valid = 1'b0;
      in_data  = '0;
   endtask

   task automatic collect_bytes(input bit random_ready);
      int idx;
      idx = 0;
      while (idx < exp_q.size()) begin
         @(posedge clk);
         #2;
         rng       = xorshift32(rng);
         out_ready = random_ready ? rng[0] : 1'b1;
         @(negedge clk);
         if (out_valid && out_ready) begin
            check_byte("out_data", out_data, exp_q[idx]);
            idx++;
         end
      end
      @(posedge clk);
      #2;
      out_ready = 1'b1;
   endtask

   task automatic run_stream(input bit random_ready);
      apply_reset();
      cycle_count = 0;
      cycle_limit = 40 * exp_q.size() + 2000;
      saw_stall   = 1'b0;
      @(posedge clk);
      #2;
      start = 1'b1;
      @(posedge clk);
      #2;
      start = 1'b0;
      check_bit("done", done, 1'b0);
      fork
         feed_words();
         collect_bytes(random_ready);
      join
      while (!done) begin
         @(negedge clk);
      end
      repeat (4) @(negedge clk);
      check_bit("done", done, 1'b1);             // held until reset
      check_bit("out_valid", out_valid, 1'b0);   // no extra bytes
   endtask

   task automatic builder_selftest();
      lzs_token_u got;
      lzs_token_u want;
      clear_stream();
      add_literal(8'h3c);
      flush_word();
      got = word_q[0][15:3];
      want.lit.is_ref   = 1'b0;
      want.lit.lit_byte = 8'h3c;
      want.lit.pad      = 4'h0;
      check_token("literal window", got, want);
      repeat (2047) exp_q.push_back(8'h00);   // history for the offsets below
      word_q.delete();
      add_copy(85, 2);
      flush_word();
      got = word_q[0][15:3];
      want.bref.is_ref    = 1'b1;
      want.bref.short_off = 1'b1;
      want.bref.off_field = {7'd85, 4'h0};
      check_token("short ref window", got, want);
      word_q.delete();
      add_copy(1443, 3);
      flush_word();
      got = word_q[0][15:3];
      want.bref.short_off = 1'b0;
      want.bref.off_field = 11'd1443;
      check_token("long ref window", got, want);
   endtask

   task automatic literal_run();
      clear_stream();
      for (int i = 0; i < 24; i++) begin
         rng = xorshift32(rng);
         add_literal(rng[7:0]);
      end
      close_stream();
      run_stream(1'b0);
   endtask

   task automatic short_offset_copies();
      clear_stream();
      for (int i = 0; i < 16; i++) begin
         add_literal(8'(8'h41 + i));
      end
      add_copy(3, 2);
      add_copy(5, 3);
      add_copy(16, 4);
      add_copy(2, 5);
      add_copy(9, 6);
      add_copy(30, 7);
      add_literal(8'h5a);
      close_stream();
      run_stream(1'b0);
   endtask

   task automatic long_offset_copies();
      clear_stream();
      for (int i = 0; i < 200; i++) begin
         rng = xorshift32(rng);
         add_literal(rng[7:0]);
      end
      add_copy(150, 8);
      add_copy(190, 22);
      add_copy(220, 38);   // two 1111 nibbles then 0000
      close_stream();
      run_stream(1'b0);
   endtask

   task automatic overlap_copy();
      clear_stream();
      add_literal(8'h78);
      add_literal(8'h79);
      add_literal(8'h7a);
      add_copy(1, 20);
      add_literal(8'h21);
      close_stream();
      run_stream(1'b0);
   endtask

   task automatic backpressure_mix();
      int off;
      int len;
      int lim;
      clear_stream();
      for (int t = 0; t < 300; t++) begin
         rng = xorshift32(rng);
         if (exp_q.size() < 2 || rng[0]) begin
            add_literal(rng[15:8]);
         end else begin
            len = 2 + int'(rng[21:16]) % 40;
            lim = (exp_q.size() > 2047) ? 2047 : exp_q.size();
            rng = xorshift32(rng);
            if (lim > 127 && rng[1]) begin
               off = 128 + int'(rng % 32'(lim - 127));
            end else begin
               lim = (lim > 127) ? 127 : lim;
               off = 1 + int'(rng % 32'(lim));
            end
            add_copy(off, len);
         end
      end
      close_stream();
      run_stream(1'b1);
      check_bit("in_ready low seen", saw_stall, 1'b1);
   endtask

   initial begin
      rst       = 1'b1;
      start     = 1'b0;
      in_data   = '0;
      in_valid  = 1'b0;
      out_ready = 1'b1;
      saw_stall = 1'b0;
      builder_selftest();
      literal_run();
      short_offset_copies();
      long_offset_copies();
      overlap_copy();
      backpressure_mix();
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// File: lzs_decomp.f
logic/lzs_pkg.sv
logic/history_ram.sv
logic/out_fifo.sv
logic/bit_aligner.sv
logic/lzs_decode_ctl.sv
logic/lzs_decomp_top.sv
verif/tb_lzs_decomp.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the LZS decompressor testbench, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_lzs_decomp -f lzs_decomp.f -o sim_lzs_decomp \
   && ./obj_dir/sim_lzs_decomp > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^SIMULATION PASSED$" sim.log && exit 0 || exit 1
